//--- byp_ctrl.f
verilog/byp_rf_pkg.sv
verilog/byp_pipe_pkg.sv
verilog/byp_hazard_match.sv
verilog/byp_stall_ctrl.sv
verilog/byp_fwd_sel.sv
verilog/byp_ctrl.sv
tests/byp_ctrl_tb.sv

//--- Bender.yml
package:
  name: byp_ctrl

sources:
  # Operand bypass and hazard unit, packages ahead of the modules using them
  - files:
      - verilog/byp_rf_pkg.sv
      - verilog/byp_pipe_pkg.sv
      - verilog/byp_hazard_match.sv
      - verilog/byp_stall_ctrl.sv
      - verilog/byp_fwd_sel.sv
      - verilog/byp_ctrl.sv

  # Self-checking testbench, top module byp_ctrl_tb
  - target: test
    files:
      - tests/byp_ctrl_tb.sv

//--- tests/byp_ctrl_tb.sv
module byp_ctrl_tb import byp_rf_pkg::*, byp_pipe_pkg::*; ();

  ////////////////////////////////////////////////////////////
  // Run length
  ////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 3;
  // Allowance for all directed tests together, the real count is lower
  localparam int DIRECTED_CYCLES = 80;
  localparam int NUM_RANDOM      = 400;
  // A quarter on top of the planned cycles as margin, about 600
  localparam int MAX_CYCLES = (RESET_CYCLES + DIRECTED_CYCLES + NUM_RANDOM) * 5 / 4;

  logic                      clk_i;
  logic                      rst_n_i;
  logic [NUM_READ_PORTS-1:0] rf_re_id_i;
  rf_raddr_vec_t             rf_raddr_id_i;
  id_dec_t                   id_i;
  stage_t                    ex_i;
  stage_t                    wb_i;
  logic                      wb_ready_i;
  ctrl_byp_t                 ctrl_byp_o;

  // Reference model output for the vector currently applied
  ctrl_byp_t exp_byp;

  int    err_count    = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  int    errs_at_start;
  int    cycle_count  = 0;
  string test_name;

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  byp_ctrl DUT (
    .rf_re_id_i    (rf_re_id_i),
    .rf_raddr_id_i (rf_raddr_id_i),
    .id_i          (id_i),
    .ex_i          (ex_i),
    .wb_i          (wb_i),
    .wb_ready_i    (wb_ready_i),
    .ctrl_byp_o    (ctrl_byp_o)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // A read port depends on a stage that really writes the same nonzero register
  function automatic logic port_matches(input logic re, input rf_addr_t ra, input stage_t s);
    return s.instr_valid && s.rf_we && re && (ra != '0) && (ra == s.rf_waddr);
  endfunction

  function automatic ctrl_byp_t expected_ctrl(
    input logic [NUM_READ_PORTS-1:0] re,
    input rf_raddr_vec_t             ra,
    input id_dec_t                   id,
    input stage_t                    ex,
    input stage_t                    wb,
    input logic                      wb_rdy
  );
    ctrl_byp_t                 c;
    logic [NUM_READ_PORTS-1:0] hit_ex;
    logic [NUM_READ_PORTS-1:0] hit_wb;
    logic                      jr_ex;
    logic                      jr_wb;
    hit_ex[0] = port_matches(re[0], ra[0], ex);
    hit_ex[1] = port_matches(re[1], ra[1], ex);
    hit_wb[0] = port_matches(re[0], ra[0], wb);
    hit_wb[1] = port_matches(re[1], ra[1], wb);
    // The jump target always reads rs1 whatever its enable says
    jr_ex = port_matches(1'b1, ra[0], ex);
    jr_wb = port_matches(1'b1, ra[0], wb);
    c.load_stall = (ex.lsu_en && (|hit_ex)) || (!wb_rdy && (|hit_wb));
    c.jalr_stall = id.instr_valid && id.jmpr && (jr_ex || (jr_wb && wb.lsu_en));
    c.csr_stall  = id.instr_valid && (id.csr_en || id.sys_mret || id.sys_wfi) &&
                   ((ex.instr_valid && (ex.csr_en || ex.sys_mret)) ||
                    (wb.instr_valid && (wb.csr_en || wb.sys_mret)));
    c.wfi_stall  = ex.instr_valid && ex.sys_wfi;
    // The younger EX result wins over WB
    c.operand_a_sel = hit_ex[0] ? SEL_FW_EX : (hit_wb[0] ? SEL_FW_WB : SEL_REGFILE);
    c.operand_b_sel = hit_ex[1] ? SEL_FW_EX : (hit_wb[1] ? SEL_FW_WB : SEL_REGFILE);
    c.jalr_sel      = jr_wb ? SELJ_FW_WB : SELJ_REGFILE;
    return c;
  endfunction

  always_comb begin
    exp_byp = expected_ctrl(rf_re_id_i, rf_raddr_id_i, id_i, ex_i, wb_i, wb_ready_i);
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic report_fail(input string msg);
    err_count++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // With every valid low the unit must neither stall nor forward
  a_reset_idle: assert property (@(posedge clk_i) !rst_n_i |-> (ctrl_byp_o == '0))
    else report_fail($sformatf("outputs in reset are 'h%0h, expected all idle", ctrl_byp_o));

  a_load_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_byp_o.load_stall == exp_byp.load_stall)
    else report_fail($sformatf("load_stall is %0d, expected %0d",
                               ctrl_byp_o.load_stall, exp_byp.load_stall));

  a_jalr_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_byp_o.jalr_stall == exp_byp.jalr_stall)
    else report_fail($sformatf("jalr_stall is %0d, expected %0d",
                               ctrl_byp_o.jalr_stall, exp_byp.jalr_stall));

  a_csr_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_byp_o.csr_stall == exp_byp.csr_stall)
    else report_fail($sformatf("csr_stall is %0d, expected %0d",
                               ctrl_byp_o.csr_stall, exp_byp.csr_stall));

  a_wfi_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_byp_o.wfi_stall == exp_byp.wfi_stall)
    else report_fail($sformatf("wfi_stall is %0d, expected %0d",
                               ctrl_byp_o.wfi_stall, exp_byp.wfi_stall));

  a_operand_a_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_byp_o.operand_a_sel == exp_byp.operand_a_sel)
    else report_fail($sformatf("operand_a_sel is %0d, expected %0d",
                               ctrl_byp_o.operand_a_sel, exp_byp.operand_a_sel));

  a_operand_b_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_byp_o.operand_b_sel == exp_byp.operand_b_sel)
    else report_fail($sformatf("operand_b_sel is %0d, expected %0d",
                               ctrl_byp_o.operand_b_sel, exp_byp.operand_b_sel));

  a_jalr_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ctrl_byp_o.jalr_sel == exp_byp.jalr_sel)
    else report_fail($sformatf("jalr_sel is %0d, expected %0d",
                               ctrl_byp_o.jalr_sel, exp_byp.jalr_sel));

  // Stops a run that never reaches its end
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Port 0 sits in the low bits
  function automatic rf_raddr_vec_t pack_addrs(input rf_addr_t rs1, input rf_addr_t rs2);
    return {rs2, rs1};
  endfunction

  // A valid EX or WB instruction with an optional register write
  function automatic stage_t make_stage(input logic we, input rf_addr_t rd, input logic lsu);
    stage_t s;
    s             = '0;
    s.instr_valid = 1'b1;
    s.rf_we       = we;
    s.rf_waddr    = rd;
    s.lsu_en      = lsu;
    return s;
  endfunction

  // A valid system instruction in EX or WB, it writes no register
  function automatic stage_t make_sys(input logic csr, input logic mret, input logic wfi);
    stage_t s;
    s             = '0;
    s.instr_valid = 1'b1;
    s.csr_en      = csr;
    s.sys_mret    = mret;
    s.sys_wfi     = wfi;
    return s;
  endfunction

  function automatic id_dec_t make_id(input logic v, input logic jmpr, input logic csr,
                                      input logic mret, input logic wfi);
    return '{instr_valid: v, jmpr: jmpr, csr_en: csr, sys_mret: mret, sys_wfi: wfi};
  endfunction

  // Drives one vector on the falling edge, it is checked on the next rising edge
  task automatic apply(input logic [NUM_READ_PORTS-1:0] re, input rf_raddr_vec_t ra,
                       input id_dec_t id, input stage_t ex, input stage_t wb,
                       input logic rdy);
    @(negedge clk_i);
    rf_re_id_i    = re;
    rf_raddr_id_i = ra;
    id_i          = id;
    ex_i          = ex;
    wb_i          = wb;
    wb_ready_i    = rdy;
  endtask

  // Addresses from x0 to x3 only, so matches come often
  function automatic rf_addr_t random_low_reg();
    logic [31:0] r;
    r = $urandom_range(3, 0);
    return r[RF_ADDR_W-1:0];
  endfunction

  task automatic apply_random();
    logic [31:0] r;
    stage_t      ex;
    stage_t      wb;
    id_dec_t     id;
    r           = $urandom;
    ex          = r[$bits(stage_t)-1:0];
    ex.rf_waddr = random_low_reg();
    r           = $urandom;
    wb          = r[$bits(stage_t)-1:0];
    wb.rf_waddr = random_low_reg();
    r           = $urandom;
    id          = r[$bits(id_dec_t)-1:0];
    apply(r[9:8], pack_addrs(random_low_reg(), random_low_reg()), id, ex, wb, r[12]);
  endtask

  task automatic begin_test(input string name);
    test_name     = name;
    errs_at_start = err_count;
  endtask

  // Waits until the last vector has been checked, then idles the inputs
  task automatic end_test();
    int errs;
    apply('0, '0, '0, '0, '0, 1'b1);
    errs = err_count - errs_at_start;
    if (errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("%-16s done at %0t with %0d mismatches", test_name, $time, errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    stage_t s;
    rst_n_i       = 1'b0;
    rf_re_id_i    = '0;
    rf_raddr_id_i = '0;
    id_i          = '0;
    ex_i          = '0;
    wb_i          = '0;
    wb_ready_i    = 1'b1;
    void'($urandom(71));

    begin_test("reset_idle");
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n_i = 1'b1;
    end_test();

    // EX and WB both write rs1, then only WB does, then the same for rs2
    begin_test("forward_priority");
    apply(2'b11, pack_addrs(5, 6), make_id(1, 0, 0, 0, 0), make_stage(1, 5, 0),
          make_stage(1, 5, 0), 1'b1);
    apply(2'b11, pack_addrs(5, 6), make_id(1, 0, 0, 0, 0), '0, make_stage(1, 5, 0), 1'b1);
    apply(2'b11, pack_addrs(6, 7), make_id(1, 0, 0, 0, 0), make_stage(1, 7, 0),
          make_stage(1, 7, 0), 1'b1);
    apply(2'b11, pack_addrs(6, 7), make_id(1, 0, 0, 0, 0), '0, make_stage(1, 7, 0), 1'b1);
    apply(2'b11, pack_addrs(5, 7), '0, make_stage(1, 7, 0), make_stage(1, 5, 0), 1'b1);
    end_test();

    // x0, read enable low, rf_we low and an invalid stage never forward
    begin_test("exclusions");
    apply(2'b11, pack_addrs(0, 0), '0, make_stage(1, 0, 1), make_stage(1, 0, 1), 1'b0);
    apply(2'b00, pack_addrs(5, 6), '0, make_stage(1, 5, 1), make_stage(1, 6, 0), 1'b0);
    apply(2'b11, pack_addrs(5, 6), '0, make_stage(0, 5, 1), make_stage(0, 6, 0), 1'b0);
    s             = make_stage(1, 5, 1);
    s.instr_valid = 1'b0;
    apply(2'b11, pack_addrs(5, 5), '0, s, s, 1'b0);
    end_test();

    // Load in EX, then a load in WB with and without back-pressure
    begin_test("load_use");
    apply(2'b11, pack_addrs(3, 8), '0, make_stage(1, 8, 1), '0, 1'b1);
    apply(2'b11, pack_addrs(3, 8), '0, make_stage(1, 9, 1), '0, 1'b1);
    apply(2'b11, pack_addrs(3, 8), '0, '0, make_stage(1, 8, 1), 1'b1);
    repeat (3) apply(2'b11, pack_addrs(3, 8), '0, '0, make_stage(1, 8, 1), 1'b0);
    apply(2'b11, pack_addrs(3, 8), '0, '0, make_stage(1, 8, 1), 1'b1);
    end_test();

    // JALR reading x10 against EX and WB writers of several kinds
    begin_test("jump_register");
    apply(2'b01, pack_addrs(10, 0), make_id(1, 1, 0, 0, 0), make_stage(1, 10, 0), '0, 1'b1);
    apply(2'b00, pack_addrs(10, 0), make_id(1, 1, 0, 0, 0), make_stage(1, 10, 0), '0, 1'b1);
    apply(2'b01, pack_addrs(10, 0), make_id(1, 1, 0, 0, 0), '0, make_stage(1, 10, 0), 1'b1);
    apply(2'b01, pack_addrs(10, 0), make_id(1, 1, 0, 0, 0), '0, make_stage(1, 10, 1), 1'b1);
    apply(2'b01, pack_addrs(10, 0), make_id(0, 1, 0, 0, 0), make_stage(1, 10, 0), '0, 1'b1);
    end_test();

    // CSR state readers in ID against CSR and mret writers ahead, then WFI in EX
    begin_test("csr_wfi");
    apply('0, '0, make_id(1, 0, 1, 0, 0), make_sys(1, 0, 0), '0, 1'b1);
    apply('0, '0, make_id(1, 0, 0, 1, 0), '0, make_sys(0, 1, 0), 1'b1);
    apply('0, '0, make_id(1, 0, 0, 0, 1), make_sys(1, 0, 0), '0, 1'b1);
    apply('0, '0, make_id(0, 0, 1, 0, 0), make_sys(1, 0, 0), make_sys(0, 1, 0), 1'b1);
    apply('0, '0, make_id(1, 0, 0, 0, 0), make_sys(0, 0, 1), '0, 1'b1);
    s             = make_sys(0, 0, 1);
    s.instr_valid = 1'b0;
    apply('0, '0, make_id(1, 0, 1, 0, 0), s, '0, 1'b1);
    end_test();

    begin_test("random_sweep");
    repeat (NUM_RANDOM) apply_random();
    end_test();

    $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog/byp_ctrl.sv
module byp_ctrl import byp_rf_pkg::*, byp_pipe_pkg::*; (
  // From the decoder
  input  logic [NUM_READ_PORTS-1:0] rf_re_id_i,
  input  rf_raddr_vec_t             rf_raddr_id_i,

  // Stage descriptors
  input  id_dec_t                   id_i,
  input  stage_t                    ex_i,
  input  stage_t                    wb_i,

  // WB is not stalled on the data bus
  input  logic                      wb_ready_i,

  // Stall requests and forwarding selects
  output ctrl_byp_t                 ctrl_byp_o
);

  // Match results against the two writing stages
  stage_hz_t ex_hz;
  stage_hz_t wb_hz;

  // Stall requests
  logic load_stall;
  logic jalr_stall;
  logic csr_stall;
  logic wfi_stall;

  // Mux selects
  op_fw_sel_e   operand_a_sel;
  op_fw_sel_e   operand_b_sel;
  jalr_fw_sel_e jalr_sel;

  ////////////////////////////////////////////////////////////
  // Register dependency matching
  ////////////////////////////////////////////////////////////

  byp_hazard_match u_ex_match (
    .rf_re_id_i    (rf_re_id_i),
    .rf_raddr_id_i (rf_raddr_id_i),
    .stage_i       (ex_i),
    .hz_o          (ex_hz)
  );

  byp_hazard_match u_wb_match (
    .rf_re_id_i    (rf_re_id_i),
    .rf_raddr_id_i (rf_raddr_id_i),
    .stage_i       (wb_i),
    .hz_o          (wb_hz)
  );

  // Stall decisions, the only place that looks at instruction kinds
  byp_stall_ctrl u_stall_ctrl (
    .id_i         (id_i),
    .ex_i         (ex_i),
    .wb_i         (wb_i),
    .ex_hz_i      (ex_hz),
    .wb_hz_i      (wb_hz),
    .wb_ready_i   (wb_ready_i),
    .load_stall_o (load_stall),
    .jalr_stall_o (jalr_stall),
    .csr_stall_o  (csr_stall),
    .wfi_stall_o  (wfi_stall)
  );

  // Forwarding selects from the match results alone
  byp_fwd_sel u_fwd_sel (
    .ex_hz_i         (ex_hz),
    .wb_hz_i         (wb_hz),
    .operand_a_sel_o (operand_a_sel),
    .operand_b_sel_o (operand_b_sel),
    .jalr_sel_o      (jalr_sel)
  );

  // Collect everything into the controller bundle
  assign ctrl_byp_o.load_stall    = load_stall;
  assign ctrl_byp_o.jalr_stall    = jalr_stall;
  assign ctrl_byp_o.csr_stall     = csr_stall;
  assign ctrl_byp_o.wfi_stall     = wfi_stall;
  assign ctrl_byp_o.operand_a_sel = operand_a_sel;
  assign ctrl_byp_o.operand_b_sel = operand_b_sel;
  assign ctrl_byp_o.jalr_sel      = jalr_sel;

endmodule

//--- verilog/byp_fwd_sel.sv
module byp_fwd_sel import byp_rf_pkg::*, byp_pipe_pkg::*; (
  // Register matches against EX and WB
  input  stage_hz_t    ex_hz_i,
  input  stage_hz_t    wb_hz_i,

  // Forwarding mux selects for the ID stage
  output op_fw_sel_e   operand_a_sel_o,
  output op_fw_sel_e   operand_b_sel_o,
  output jalr_fw_sel_e jalr_sel_o
);

  ////////////////////////////////////////////////////////////
  // Operand priority decode
  ////////////////////////////////////////////////////////////

  // EX holds the younger write of the two, so it wins over WB
  function automatic op_fw_sel_e op_sel(input logic ex_hit, input logic wb_hit);
    op_fw_sel_e sel;
    sel = SEL_REGFILE;
    if (ex_hit) begin
      sel = SEL_FW_EX;
    end else if (wb_hit) begin
      sel = SEL_FW_WB;
    end
    return sel;
  endfunction

  // Operand A comes from port 0 (rs1)
  assign operand_a_sel_o = op_sel(ex_hz_i.rd_hz[0], wb_hz_i.rd_hz[0]);

  // Operand B comes from port 1 (rs2)
  assign operand_b_sel_o = op_sel(ex_hz_i.rd_hz[1], wb_hz_i.rd_hz[1]);

  ////////////////////////////////////////////////////////////
  // Jump target select
  ////////////////////////////////////////////////////////////

  // There is no EX leg on this mux, an EX producer makes the jump stall
  // A load in WB also stalls, so the select is a don't care then
  always_comb begin
    jalr_sel_o = SELJ_REGFILE;
    if (wb_hz_i.jalr_hz) begin
      jalr_sel_o = SELJ_FW_WB;
    end
  end

endmodule

//--- verilog/byp_stall_ctrl.sv
module byp_stall_ctrl import byp_pipe_pkg::*; (
  // Instruction in ID
  input  id_dec_t   id_i,

  // Instructions in EX and WB
  input  stage_t    ex_i,
  input  stage_t    wb_i,

  // Register matches against EX and WB
  input  stage_hz_t ex_hz_i,
  input  stage_hz_t wb_hz_i,

  // WB is not waiting on the data bus
  input  logic      wb_ready_i,

  // Stall requests towards the controller
  output logic      load_stall_o,
  output logic      jalr_stall_o,
  output logic      csr_stall_o,
  output logic      wfi_stall_o
);

  // Any operand of ID depends on EX or on WB
  logic rd_dep_ex;
  logic rd_dep_wb;

  // Load or store in WB whose result is still on its way
  logic lsu_in_wb;

  // A jump through a register sits in ID
  logic jmpr_id;

  // ID reads CSR state, including the implicit reads of mret and WFI
  logic csr_rd_id;

  // EX or WB writes CSR state, explicitly or through mret
  logic csr_wr_ex;
  logic csr_wr_wb;

  assign rd_dep_ex = |ex_hz_i.rd_hz;
  assign rd_dep_wb = |wb_hz_i.rd_hz;

  // The WB match already implies a valid instruction in WB
  assign lsu_in_wb = wb_i.lsu_en;

  assign jmpr_id   = id_i.instr_valid && id_i.jmpr;

  ////////////////////////////////////////////////////////////
  // Load-use stall
  ////////////////////////////////////////////////////////////

  // Load data only exists once the bus has answered, which is after EX
  // While WB waits on the bus its result can not be forwarded either
  assign load_stall_o = (ex_i.lsu_en && rd_dep_ex) ||
                        (!wb_ready_i && rd_dep_wb);

  ////////////////////////////////////////////////////////////
  // Jump register stall
  ////////////////////////////////////////////////////////////

  // The jump target mux has no EX input, so any EX producer stalls
  // From WB only ALU results are forwarded; load data is too late
  assign jalr_stall_o = jmpr_id &&
                        (ex_hz_i.jalr_hz || (wb_hz_i.jalr_hz && lsu_in_wb));

  ////////////////////////////////////////////////////////////
  // CSR and WFI stalls
  ////////////////////////////////////////////////////////////

  assign csr_rd_id = id_i.instr_valid &&
                     (id_i.csr_en || id_i.sys_mret || id_i.sys_wfi);

  assign csr_wr_ex = ex_i.instr_valid && (ex_i.csr_en || ex_i.sys_mret);
  assign csr_wr_wb = wb_i.instr_valid && (wb_i.csr_en || wb_i.sys_mret);

  // Conservative check, any CSR write ahead blocks any CSR read in ID
  // It does not compare CSR addresses
  assign csr_stall_o = csr_rd_id && (csr_wr_ex || csr_wr_wb);

  // Keep loads and stores behind a WFI while it is in EX
  assign wfi_stall_o = ex_i.instr_valid && ex_i.sys_wfi;

endmodule

//--- verilog/byp_hazard_match.sv
module byp_hazard_match import byp_rf_pkg::*, byp_pipe_pkg::*; (
  // Read enables and addresses from the decoder
  input  logic [NUM_READ_PORTS-1:0] rf_re_id_i,
  input  rf_raddr_vec_t             rf_raddr_id_i,

  // The stage that may be writing the register file
  input  stage_t                    stage_i,

  // Qualified match results
  output stage_hz_t                 hz_o
);

  // Stage holds a live instruction that will write a register
  logic stage_wr;

  // Address compares, one per read port, not yet qualified
  logic [NUM_READ_PORTS-1:0] addr_eq;

  // Nonzero read address per port, x0 never produces a hazard
  logic [NUM_READ_PORTS-1:0] addr_nz;

  assign stage_wr = stage_i.instr_valid && stage_i.rf_we;

  ////////////////////////////////////////////////////////////
  // Operand read ports
  ////////////////////////////////////////////////////////////

  genvar g_port;
  generate
    for (g_port = 0; g_port < NUM_READ_PORTS; g_port++) begin : gen_port_match
      assign addr_eq[g_port] = (rf_raddr_id_i[g_port] == stage_i.rf_waddr);

      // Reads of x0 return zero, so a write to x0 must not forward
      assign addr_nz[g_port] = |rf_raddr_id_i[g_port];

      // Every term must hold for the operand to depend on this stage
      assign hz_o.rd_hz[g_port] = stage_wr && rf_re_id_i[g_port] &&
                                  addr_nz[g_port] && addr_eq[g_port];
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // Jump target path
  ////////////////////////////////////////////////////////////

  // A JALR always reads rs1, so the read enable is left out here
  // The result only matters when ID really holds a jump
  assign hz_o.jalr_hz = stage_wr && addr_nz[0] && addr_eq[0];

endmodule

//--- verilog/byp_pipe_pkg.sv
package byp_pipe_pkg;

  import byp_rf_pkg::*;

  ////////////////////////////////////////////////////////////
  // Stage descriptors
  ////////////////////////////////////////////////////////////

  // Decoded view of the instruction sitting in ID
  // Only the bits that can create a hazard are carried here
  typedef struct packed {
    logic instr_valid;
    // Jump through a register (JALR)
    logic jmpr;
    // Explicit CSR access
    logic csr_en;
    // mret writes mstatus implicitly
    logic sys_mret;
    // WFI reads mstatus.tw and the privilege level
    logic sys_wfi;
  } id_dec_t;

  // Descriptor of the instruction in EX or in WB
  typedef struct packed {
    logic     instr_valid;
    // Register file write enable and destination
    logic     rf_we;
    rf_addr_t rf_waddr;
    // Load or store, the result is not ready for EX forwarding
    logic     lsu_en;
    logic     csr_en;
    logic     sys_mret;
    logic     sys_wfi;
  } stage_t;

  ////////////////////////////////////////////////////////////
  // Hazard match result against one writing stage
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    // One bit per ID read port, already qualified with valid and rf_we
    logic [NUM_READ_PORTS-1:0] rd_hz;
    // rs1 match for the jump target, read enable not considered
    logic                      jalr_hz;
  } stage_hz_t;

  ////////////////////////////////////////////////////////////
  // Controller outputs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic         load_stall;
    logic         jalr_stall;
    logic         csr_stall;
    logic         wfi_stall;
    op_fw_sel_e   operand_a_sel;
    op_fw_sel_e   operand_b_sel;
    jalr_fw_sel_e jalr_sel;
  } ctrl_byp_t;

endpackage

//--- verilog/byp_rf_pkg.sv
package byp_rf_pkg;

  ////////////////////////////////////////////////////////////
  // Register file geometry
  ////////////////////////////////////////////////////////////

  // Width of a register address, 32 architectural registers
  localparam int unsigned RF_ADDR_W = 5;

  // Number of register file read ports used by the ID stage
  // Port 0 carries rs1 and port 1 carries rs2
  localparam int unsigned NUM_READ_PORTS = 2;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  // All ID read addresses side by side, port 0 in the low bits
  typedef rf_addr_t [NUM_READ_PORTS-1:0] rf_raddr_vec_t;

  ////////////////////////////////////////////////////////////
  // Forwarding mux selects
  ////////////////////////////////////////////////////////////

  // Operand select, value 2'b11 is left free for later sources
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } op_fw_sel_e;

  // The jump target path only forwards from WB, never from EX
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_fw_sel_e;

endpackage
